//--- common/mem_system_pkg.sv
package mem_system_pkg;

   // Address and data
   localparam int addr_w = 16;
   localparam int data_w = 16;
   localparam int tag_w = 8;
   localparam int index_w = 5;
   localparam int offset_w = 2;
   localparam int word_addr_w = addr_w - 1;             // Byte bit 0 dropped
   localparam int bank_addr_w = word_addr_w - offset_w;

   // Cache geometry
   localparam int num_lines = 32;
   localparam int words_per_line = 4;                   // Same as the bank count

   // Banked memory
   localparam int bank_depth = 8192;
   localparam int bank_latency = 2;
   localparam int bank_busy_cycles = 4;
   localparam int busy_cnt_w = $clog2(bank_busy_cycles + 1);

   typedef enum logic [1:0] {
      mem_op_none = 2'd0,
      mem_op_rd   = 2'd1,
      mem_op_wr   = 2'd2
   } mem_op_e;

   typedef enum logic [2:0] {
      idle       = 3'd0,
      compare    = 3'd1,
      write_back = 3'd2,
      fill_req   = 3'd3,
      fill_wait  = 3'd4,
      finish     = 3'd5
   } ctrl_state_e;

   typedef struct packed {
      mem_op_e                op;
      logic [word_addr_w-1:0] addr;
      logic [data_w-1:0]      data;
   } mem_req_t;

   typedef struct packed {
      logic               enable;
      logic               comp;
      logic               write;
      logic               valid_in;
      logic [tag_w-1:0]   tag;
      logic [index_w-1:0] index;
      logic [offset_w-1:0] offset;
      logic [data_w-1:0]  data;
   } cache_req_t;

   typedef struct packed {
      logic              hit;
      logic              dirty;
      logic              valid;
      logic [tag_w-1:0]  tag_out;
      logic [data_w-1:0] data;
   } cache_rsp_t;

   typedef struct packed {
      logic                rd_valid;
      logic [offset_w-1:0] rd_offset;
      logic [data_w-1:0]   rd_data;
   } mem_rsp_t;

endpackage

//--- cache/cache_array.sv
`timescale 1ns/10ps

module cache_array (
   input  logic                       clk,
   input  logic                       rst,
   input  mem_system_pkg::cache_req_t cache_req,
   output mem_system_pkg::cache_rsp_t cache_rsp
);
   import mem_system_pkg::*;

   logic [tag_w-1:0]  tag_mem [num_lines];
   logic [data_w-1:0] data_mem [num_lines][words_per_line];
   logic [num_lines-1:0] valid_q;
   logic [num_lines-1:0] dirty_q;
   logic tag_match;
   logic hit;
   logic wr_data;
   logic wr_fill;

   assign tag_match = tag_mem[cache_req.index] == cache_req.tag;
   assign hit = cache_req.enable && cache_req.comp && valid_q[cache_req.index] && tag_match;

   // Compare mode only writes on a hit, access mode always writes
   assign wr_data = cache_req.enable && cache_req.write && (cache_req.comp ? hit : 1'b1);
   assign wr_fill = cache_req.enable && cache_req.write && !cache_req.comp && cache_req.valid_in;

   assign cache_rsp.hit     = hit;
   assign cache_rsp.dirty   = dirty_q[cache_req.index];
   assign cache_rsp.valid   = valid_q[cache_req.index];
   assign cache_rsp.tag_out = tag_mem[cache_req.index];   // Victim tag for write-back
   assign cache_rsp.data    = data_mem[cache_req.index][cache_req.offset];

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (wr_fill) begin
            valid_q[cache_req.index] <= 1'b1;
            dirty_q[cache_req.index] <= 1'b0;   // Fresh line from memory
         end else if (wr_data && cache_req.comp) begin
            dirty_q[cache_req.index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fill) begin
         tag_mem[cache_req.index] <= cache_req.tag;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_data) begin
         data_mem[cache_req.index][cache_req.offset] <= cache_req.data;
      end
   end

endmodule

//--- cache/cache_ctrl.sv
`timescale 1ns/10ps

module cache_ctrl (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [mem_system_pkg::addr_w-1:0] addr,
   input  logic [mem_system_pkg::data_w-1:0] data_in,
   input  logic                              rd,
   input  logic                              wr,
   output mem_system_pkg::cache_req_t        cache_req,
   input  mem_system_pkg::cache_rsp_t        cache_rsp,
   output mem_system_pkg::mem_req_t          mem_req,
   input  logic                              mem_stall,
   input  mem_system_pkg::mem_rsp_t          mem_rsp,
   output logic [mem_system_pkg::data_w-1:0] data_out,
   output logic                              done,
   output logic                              stall,
   output logic                              cache_hit,
   output logic                              req_err
);
   import mem_system_pkg::*;

   ctrl_state_e state;
   ctrl_state_e state_nxt;
   logic [addr_w-1:0]   req_addr;
   logic [data_w-1:0]   req_data;
   logic                req_wr;
   logic                missed;
   logic [offset_w-1:0] wb_cnt;
   logic [offset_w-1:0] fill_cnt;
   logic [offset_w-1:0] ret_cnt;
   logic [tag_w-1:0]    req_tag;
   logic [index_w-1:0]  req_index;
   logic [offset_w-1:0] req_offset;
   logic                accept;
   logic                filling;

   assign req_tag    = req_addr[addr_w-1 -: tag_w];
   assign req_index  = req_addr[offset_w+1 +: index_w];
   assign req_offset = req_addr[1 +: offset_w];

   assign req_err = (rd | wr) && (addr[0] || (rd && wr));
   assign accept  = (state == idle) && (rd ^ wr) && !addr[0];
   assign filling = (state == fill_req) || (state == fill_wait);

   always_comb begin
      state_nxt = state;
      cache_req = '0;
      cache_req.tag    = req_tag;
      cache_req.index  = req_index;
      cache_req.offset = req_offset;
      cache_req.data   = req_data;
      mem_req = '0;

      case (state)
         idle: begin
            if (accept) begin
               state_nxt = compare;
            end
         end
         compare: begin
            cache_req.enable = 1'b1;
            cache_req.comp   = 1'b1;
            cache_req.write  = req_wr;
            if (cache_rsp.hit) begin
               state_nxt = finish;
            end else if (cache_rsp.valid && cache_rsp.dirty) begin
               state_nxt = write_back;
            end else begin
               state_nxt = fill_req;
            end
         end
         write_back: begin
            cache_req.enable = 1'b1;     // Access read of the victim word
            cache_req.offset = wb_cnt;
            mem_req.op   = mem_op_wr;
            mem_req.addr = {cache_rsp.tag_out, req_index, wb_cnt};
            mem_req.data = cache_rsp.data;
            if (!mem_stall && wb_cnt == offset_w'(words_per_line - 1)) begin
               state_nxt = fill_req;
            end
         end
         fill_req: begin
            mem_req.op   = mem_op_rd;
            mem_req.addr = {req_tag, req_index, fill_cnt};
            if (!mem_stall && fill_cnt == offset_w'(words_per_line - 1)) begin
               state_nxt = fill_wait;
            end
         end
         fill_wait: begin
            if (mem_rsp.rd_valid && ret_cnt == offset_w'(words_per_line - 1)) begin
               state_nxt = compare;
            end
         end
         finish: begin
            cache_req.enable = 1'b1;
            state_nxt = idle;
         end
         default: begin
            state_nxt = idle;
         end
      endcase

      // Returning fill words go straight into the line
      if (filling && mem_rsp.rd_valid) begin
         cache_req.enable   = 1'b1;
         cache_req.write    = 1'b1;
         cache_req.valid_in = 1'b1;
         cache_req.offset   = mem_rsp.rd_offset;
         cache_req.data     = mem_rsp.rd_data;
      end

      // Address and data stay put, only the strobe waits for the bank
      if (mem_stall) begin
         mem_req.op = mem_op_none;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= idle;
         missed   <= 1'b0;
         wb_cnt   <= '0;
         fill_cnt <= '0;
         ret_cnt  <= '0;
      end else begin
         state <= state_nxt;
         if (accept) begin
            missed   <= 1'b0;
            wb_cnt   <= '0;
            fill_cnt <= '0;
            ret_cnt  <= '0;
         end
         if (state == compare && !cache_rsp.hit) begin
            missed <= 1'b1;   // Keeps CacheHit low after the refill
         end
         if (state == write_back && !mem_stall) begin
            wb_cnt <= wb_cnt + 1'b1;
         end
         if (state == fill_req && !mem_stall) begin
            fill_cnt <= fill_cnt + 1'b1;
         end
         if (filling && mem_rsp.rd_valid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
   end

   assign done      = state == finish;
   assign stall     = state != idle;
   assign cache_hit = done && !missed;
   assign data_out  = cache_rsp.data;   // Line word as seen in finish

endmodule

//--- mem/mem_bank.sv
`timescale 1ns/10ps

module mem_bank (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   req,
   input  mem_system_pkg::mem_op_e                op,
   input  logic [mem_system_pkg::bank_addr_w-1:0] addr,
   input  logic [mem_system_pkg::data_w-1:0]      data_in,
   output logic                                   busy,
   output logic                                   rd_valid,
   output logic [mem_system_pkg::data_w-1:0]      rd_data
);
   import mem_system_pkg::*;

   logic [data_w-1:0] mem [bank_depth];
   logic [data_w-1:0] data_pipe [bank_latency];
   logic [bank_latency-1:0] vld_pipe;
   logic [busy_cnt_w-1:0]   busy_cnt;
   logic accept;
   logic rd_acc;

   assign accept = req && !busy;
   assign rd_acc = accept && op == mem_op_rd;
   assign busy   = busy_cnt != '0;

   // Contents start at zero and survive reset
   initial begin
      for (int i = 0; i < bank_depth; i++) begin
         mem[i] = '0;
      end
   end

   always @(posedge clk) begin
      if (accept && op == mem_op_wr) begin
         mem[addr] <= data_in;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_acc) begin
         data_pipe[0] <= mem[addr];
      end
      for (int i = 1; i < bank_latency; i++) begin
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         vld_pipe <= '0;
         busy_cnt <= '0;
      end else begin
         vld_pipe <= {vld_pipe[bank_latency-2:0], rd_acc};
         if (accept) begin
            busy_cnt <= busy_cnt_w'(bank_busy_cycles);
         end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
         end
      end
   end

   assign rd_valid = vld_pipe[bank_latency-1];
   assign rd_data  = data_pipe[bank_latency-1];

endmodule

//--- mem/four_bank_mem.sv
`timescale 1ns/10ps

module four_bank_mem (
   input  logic                                      clk,
   input  logic                                      rst,
   input  mem_system_pkg::mem_req_t                  mem_req,
   output logic                                      stall,
   output logic [mem_system_pkg::words_per_line-1:0] busy,
   output mem_system_pkg::mem_rsp_t                  mem_rsp,
   output logic                                      err
);
   import mem_system_pkg::*;

   logic [offset_w-1:0]       bank_sel;
   logic [bank_addr_w-1:0]    bank_addr;
   logic [words_per_line-1:0] strobe;
   logic [words_per_line-1:0] rd_vld;
   logic [data_w-1:0]         rd_dat [words_per_line];

   // Word interleave, low word-address bits pick the bank
   assign bank_sel  = mem_req.addr[offset_w-1:0];
   assign bank_addr = mem_req.addr[word_addr_w-1:offset_w];

   for (genvar i = 0; i < words_per_line; i++) begin : g_bank
      assign strobe[i] = (mem_req.op != mem_op_none) && (bank_sel == i);

      mem_bank u_mem_bank (
         .clk      (clk),
         .rst      (rst),
         .req      (strobe[i]),
         .op       (mem_req.op),
         .addr     (bank_addr),
         .data_in  (mem_req.data),
         .busy     (busy[i]),
         .rd_valid (rd_vld[i]),
         .rd_data  (rd_dat[i])
      );
   end

   assign stall = busy[bank_sel];
   assign err   = |(strobe & busy);

   // At most one bank returns per cycle
   always_comb begin
      mem_rsp = '0;
      for (int i = 0; i < words_per_line; i++) begin
         if (rd_vld[i]) begin
            mem_rsp.rd_valid  = 1'b1;
            mem_rsp.rd_offset = offset_w'(i);
            mem_rsp.rd_data   = rd_dat[i];
         end
      end
   end

endmodule

//--- verilog/mem_system.sv
`timescale 1ns/10ps

module mem_system (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [mem_system_pkg::addr_w-1:0] Addr,
   input  logic [mem_system_pkg::data_w-1:0] DataIn,
   input  logic                              Rd,
   input  logic                              Wr,
   output logic [mem_system_pkg::data_w-1:0] DataOut,
   output logic                              Done,
   output logic                              Stall,
   output logic                              CacheHit,
   output logic                              err
);
   import mem_system_pkg::*;

   cache_req_t cache_req;
   cache_rsp_t cache_rsp;
   mem_req_t   mem_req;
   mem_rsp_t   mem_rsp;
   logic              mem_stall;
   logic              mem_err;
   logic              req_err;
   logic [data_w-1:0] ctrl_data;
   logic [data_w-1:0] data_q;

   cache_ctrl u_cache_ctrl (
      .clk       (clk),
      .rst       (rst),
      .addr      (Addr),
      .data_in   (DataIn),
      .rd        (Rd),
      .wr        (Wr),
      .cache_req (cache_req),
      .cache_rsp (cache_rsp),
      .mem_req   (mem_req),
      .mem_stall (mem_stall),
      .mem_rsp   (mem_rsp),
      .data_out  (ctrl_data),
      .done      (Done),
      .stall     (Stall),
      .cache_hit (CacheHit),
      .req_err   (req_err)
   );

   cache_array u_cache_array (
      .clk       (clk),
      .rst       (rst),
      .cache_req (cache_req),
      .cache_rsp (cache_rsp)
   );

   four_bank_mem u_four_bank_mem (
      .clk     (clk),
      .rst     (rst),
      .mem_req (mem_req),
      .stall   (mem_stall),
      .busy    (),
      .mem_rsp (mem_rsp),
      .err     (mem_err)
   );

   assign err = req_err | mem_err;

   // Last completed word, shown between Done pulses
   always_ff @(posedge clk) begin
      if (rst) begin
         data_q <= '0;
      end else if (Done) begin
         data_q <= ctrl_data;
      end
   end

   assign DataOut = Done ? ctrl_data : data_q;

endmodule

//--- verification/tb_mem_system.sv
`timescale 1ns/10ps

module tb_mem_system;
   import mem_system_pkg::*;

   localparam int clk_period = 40;
   localparam int random_ops = 200;
   localparam int directed_ops = 12;
   localparam int max_wait = 40;      // Worst-case cycles for one access
   localparam int watchdog_ns = (random_ops + directed_ops) * max_wait * clk_period * 2;

   logic clk;
   logic rst;
   logic [addr_w-1:0] Addr;
   logic [data_w-1:0] DataIn;
   logic Rd;
   logic Wr;
   logic [data_w-1:0] DataOut;
   logic Done;
   logic Stall;
   logic CacheHit;
   logic err;

   logic [data_w-1:0] mem_model [2**word_addr_w];
   logic [tag_w-1:0]  tag_model [num_lines];
   logic [num_lines-1:0] valid_model;
   logic [data_w-1:0] last_value;    // DataOut seen at the last Done
   logic outstanding;
   logic expect_err;
   string test_name;
   int mismatch_errors;
   int other_errors;

   mem_system u_mem_system (
      .clk      (clk),
      .rst      (rst),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .Rd       (Rd),
      .Wr       (Wr),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   assert property (@(posedge clk) disable iff (rst) outstanding |-> Stall)
      else begin
         other_errors++;
         $display("Stall low while a request is outstanding in %s", test_name);
      end

   assert property (@(posedge clk) disable iff (rst) Done |-> outstanding)
      else begin
         other_errors++;
         $display("Done pulsed with no request outstanding in %s", test_name);
      end

   assert property (@(posedge clk) disable iff (rst) CacheHit |-> Done)
      else begin
         other_errors++;
         $display("CacheHit high outside a Done cycle in %s", test_name);
      end

   assert property (@(posedge clk) disable iff (rst) !expect_err |-> !err)
      else begin
         other_errors++;
         $display("err raised during legal traffic in %s", test_name);
      end

   // Register keeps the word between Done pulses
   assert property (@(posedge clk) disable iff (rst) !Done |-> DataOut == last_value)
      else begin
         mismatch_errors++;
         $display("mismatch %s DataOut hold: expected %h, actual %h",
                  test_name, $sampled(last_value), $sampled(DataOut));
      end

   initial begin
      #(watchdog_ns);
      $display("Timeout after %0d ns, the run did not complete", watchdog_ns);
      $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
      $display("Result: FAILED");
      $finish;
   end

   task automatic check_value(input string name, input logic [data_w-1:0] expected,
                              input logic [data_w-1:0] actual);
      assert (actual === expected)
         else begin
            mismatch_errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
         end
   endtask

   task automatic do_access(input logic is_wr, input logic [addr_w-1:0] a,
                            input logic [data_w-1:0] d, input string name);
      logic [word_addr_w-1:0] waddr;
      logic [tag_w-1:0] tag;
      logic [index_w-1:0] index;
      logic exp_hit;
      logic [data_w-1:0] exp_data;
      logic [data_w-1:0] got_data;
      logic got_hit;
      logic seen_done;
      int cycles;
      waddr = a[addr_w-1:1];
      tag = a[addr_w-1 -: tag_w];
      index = a[offset_w+1 +: index_w];
      exp_hit = valid_model[index] && tag_model[index] == tag;
      exp_data = is_wr ? d : mem_model[waddr];

      @(negedge clk);
      test_name = name;
      Addr = a;
      DataIn = d;
      Rd = !is_wr;
      Wr = is_wr;
      @(posedge clk);                     // Request edge
      @(negedge clk);
      Rd = 1'b0;
      Wr = 1'b0;
      outstanding = 1'b1;
      cycles = 1;
      seen_done = Done;
      got_data = DataOut;
      got_hit = CacheHit;
      while (!seen_done && cycles < max_wait) begin
         @(negedge clk);
         cycles++;
         seen_done = Done;
         got_data = DataOut;
         got_hit = CacheHit;
      end

      if (!seen_done) begin
         other_errors++;
         $display("No Done for %s within %0d cycles", name, max_wait);
      end else begin
         check_value(name, exp_data, got_data);
         check_value({name, " CacheHit"}, data_w'(exp_hit), data_w'(got_hit));
         if (exp_hit) begin
            check_value({name, " hit latency"}, data_w'(2), data_w'(cycles));
         end
      end

      if (is_wr) begin
         mem_model[waddr] = d;
      end
      tag_model[index] = tag;
      valid_model[index] = 1'b1;

      @(negedge clk);
      assert (!Done)
         else begin
            other_errors++;
            $display("Done held longer than one cycle in %s", name);
         end
      outstanding = 1'b0;
      last_value = got_data;
   endtask

   // Faulty request, no Done and no state change expected
   task automatic send_bad_request(input logic [addr_w-1:0] a, input logic rd_in,
                                   input logic wr_in, input string name);
      @(negedge clk);
      test_name = name;
      expect_err = 1'b1;
      Addr = a;
      DataIn = ~mem_model[a[addr_w-1:1]];
      Rd = rd_in;
      Wr = wr_in;
      @(posedge clk);
      assert (err)
         else begin
            other_errors++;
            $display("err stayed low for %s", name);
         end
      @(negedge clk);
      Rd = 1'b0;
      Wr = 1'b0;
      expect_err = 1'b0;
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
         assert (!Done && !Stall)
            else begin
               other_errors++;
               $display("Faulty request %s was accepted", name);
            end
      end
   endtask

   initial begin
      logic [addr_w-1:0] a;
      logic [data_w-1:0] d;
      logic is_wr;
      void'($urandom(32'hd5fa3e35));
      rst = 1'b1;
      Addr = '0;
      DataIn = '0;
      Rd = 1'b0;
      Wr = 1'b0;
      outstanding = 1'b0;
      expect_err = 1'b0;
      last_value = '0;
      mismatch_errors = 0;
      other_errors = 0;
      test_name = "reset";
      for (int i = 0; i < 2**word_addr_w; i++) begin
         mem_model[i] = '0;
      end
      valid_model = '0;

      repeat (16) begin
         @(negedge clk);
         assert (!Done && !Stall && !CacheHit && !err)
            else begin
               other_errors++;
               $display("Outputs not idle during reset");
            end
      end
      rst = 1'b0;
      @(negedge clk);
      assert (!Done && !Stall && !CacheHit && !err)
         else begin
            other_errors++;
            $display("Outputs not idle on the first cycle after reset");
         end

      do_access(1'b0, 16'h1234, 16'h0000, "cold read");
      do_access(1'b1, 16'h0a42, 16'hbeef, "write");
      do_access(1'b0, 16'h0a42, 16'h0000, "read after write");

      // Same index, three tags, forces a dirty victim
      do_access(1'b1, 16'h3a16, 16'hc0de, "conflict write");
      do_access(1'b0, 16'h5b16, 16'h0000, "conflict read second tag");
      do_access(1'b1, 16'h7c10, 16'h5a5a, "conflict write third tag");
      do_access(1'b0, 16'h3a16, 16'h0000, "read after eviction");

      for (int i = 0; i < random_ops; i++) begin
         a = {tag_w'($urandom_range(3, 0)), index_w'($urandom_range(3, 0)),
              offset_w'($urandom_range(3, 0)), 1'b0};
         d = data_w'($urandom());
         is_wr = 1'($urandom_range(1, 0));
         do_access(is_wr, a, d, "random");
      end

      send_bad_request(16'h0a43, 1'b1, 1'b0, "misaligned read");
      send_bad_request(16'h0a43, 1'b0, 1'b1, "misaligned write");
      send_bad_request(16'h0a42, 1'b1, 1'b1, "read and write together");
      do_access(1'b0, 16'h0a42, 16'h0000, "read after faults");

      @(negedge clk);
      $display("errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
      if (mismatch_errors == 0 && other_errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
common/mem_system_pkg.sv
cache/cache_array.sv
cache/cache_ctrl.sv
mem/mem_bank.sv
mem/four_bank_mem.sv
verilog/mem_system.sv
verification/tb_mem_system.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the mem_system testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
   --top-module tb_mem_system \
   -f project.f \
   -o sim_mem_system

./obj_dir/sim_mem_system | tee sim.log

if grep -q "Result: FAILED" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi

echo "Simulation finished, see sim.log"
